// ==== flist.f ====
+incdir+include
+incdir+testbench
hw/control_pkg.sv
hw/instr_decode.sv
hw/branch_cond.sv
hw/ctrl_sequencer.sv
hw/control_top.sv
testbench/tb_control.sv

// ==== hw/branch_cond.sv ====
`timescale 1ns/10ps
`include "control_defs.svh"

module branch_cond (
  input  control_pkg::cond_e cond,
  input  control_pkg::ccr_t  ccr,
  output logic               taken
);
  import control_pkg::*;

  logic [`CCR_W-1:0] flags;
  logic              carry;
  logic              negative;
  logic              overflow;
  logic              zero;
  logic              n_ne_v;

  assign flags = ccr;
  assign {carry, negative, overflow, zero} = flags;
  assign n_ne_v = negative ^ overflow;  // signed less than

  always_comb begin
    case (cond)
      COND_ALWAYS: taken = 1'b1;
      COND_NEVER:  taken = 1'b0;
      COND_EQ:     taken = zero;
      COND_NE:     taken = ~zero;
      COND_GTU:    taken = ~(zero | carry);
      COND_GT:     taken = ~(zero | n_ne_v);
      COND_GE:     taken = ~n_ne_v;
      COND_LE:     taken = zero | n_ne_v;
      COND_LT:     taken = n_ne_v;
      COND_GEU:    taken = ~carry;
      COND_LTU:    taken = carry;
      COND_LEU:    taken = carry | zero;
      default:     taken = 1'b0;
    endcase
  end

endmodule

// ==== hw/control_pkg.sv ====
`include "control_defs.svh"

package control_pkg;

  typedef struct packed {
    logic [`MODE_W-1:0]     mode;
    logic [`OPCODE_W-1:0]   opcode;
    logic [`REG_ADDR_W-1:0] ra;
    logic [`REG_ADDR_W-1:0] rb;
    logic [`REG_ADDR_W-1:0] rc;
  } ir_fields_t;

  typedef enum logic [3:0] {
    CLS_NOP,
    CLS_ALU_RRR,
    CLS_INC,
    CLS_DEC,
    CLS_CMP,
    CLS_UNARY,
    CLS_LDIU,
    CLS_BRANCH,
    CLS_LDA,
    CLS_JMP,
    CLS_LOAD,
    CLS_STORE,
    CLS_ILLEGAL
  } op_class_e;

  // encoding follows opcode bits 2:1 of loads and stores
  typedef enum logic [1:0] {
    SIZE_LONG = 2'd0,
    SIZE_WORD = 2'd1,
    SIZE_BYTE = 2'd2
  } access_size_e;

  typedef enum logic [3:0] {
    COND_ALWAYS,
    COND_NEVER,
    COND_EQ,
    COND_NE,
    COND_GTU,
    COND_GT,
    COND_GE,
    COND_LE,
    COND_LT,
    COND_GEU,
    COND_LTU,
    COND_LEU
  } cond_e;

  typedef struct packed {
    op_class_e    op_class;
    access_size_e size;
    cond_e        cond;
    logic [2:0]   alu_func;
    logic [3:0]   regsel;     // result select for unary ops and ldiu
    ir_fields_t   fields;
  } decoded_t;

  typedef struct packed {
    logic carry;
    logic negative;
    logic overflow;
    logic zero;
  } ccr_t;

  typedef struct packed {
    logic       bus_wait;
    logic       busfault;
    logic [1:0] bus_align;
  } bus_status_t;

  typedef struct packed {
    logic                   ir_write;
    logic                   ccr_write;
    logic [2:0]             alu_func;
    logic [2:0]             alu1sel;
    logic [2:0]             alu2sel;
    logic [3:0]             regsel;
    logic [`REG_ADDR_W-1:0] reg_read_addr1;
    logic [`REG_ADDR_W-1:0] reg_read_addr2;
    logic [`REG_ADDR_W-1:0] reg_write_addr;
    logic                   reg_write;
    logic [2:0]             mdrsel;
    logic [1:0]             marsel;
    logic [2:0]             pcsel;
    logic                   addrsel;
    logic [`LANES-1:0]      byteenable;
    logic                   bus_read;
    logic                   bus_write;
  } ctrl_word_t;

  typedef enum logic [2:0] {
    ST_RESET,
    ST_FETCH,
    ST_EVAL,
    ST_EXCEPTION,
    ST_HALT
  } ctrl_state_e;

endpackage

// ==== hw/control_top.sv ====
`timescale 1ns/10ps
`include "control_defs.svh"

module control_top (
  input  logic                     clock,
  input  logic                     reset_n,
  input  logic [`DATA_W-1:0]       ir,
  input  control_pkg::ccr_t        ccr,
  input  control_pkg::bus_status_t bus,
  output control_pkg::ctrl_word_t  ctrl,
  output logic                     halt
);
  import control_pkg::*;

  decoded_t dec;
  logic     taken;

  instr_decode u_decode (
    .ir  (ir),
    .dec (dec)
  );

  // only the branch condition needs the flags
  branch_cond u_cond (
    .cond  (dec.cond),
    .ccr   (ccr),
    .taken (taken)
  );

  ctrl_sequencer u_seq (
    .clock   (clock),
    .reset_n (reset_n),
    .dec     (dec),
    .taken   (taken),
    .bus     (bus),
    .ctrl    (ctrl),
    .halt    (halt)
  );

endmodule

// ==== hw/ctrl_sequencer.sv ====
`timescale 1ns/10ps
`include "control_defs.svh"

module ctrl_sequencer (
  input  logic                     clock,
  input  logic                     reset_n,
  input  control_pkg::decoded_t    dec,
  input  logic                     taken,
  input  control_pkg::bus_status_t bus,
  output control_pkg::ctrl_word_t  ctrl,
  output logic                     halt
);
  import control_pkg::*;

  ctrl_state_e       state;
  ctrl_state_e       state_next;
  logic [`SEQ_W-1:0] step;
  logic [`SEQ_W-1:0] step_next;
  logic [`LANES-1:0] lane_mask;
  logic              eval_done;
  logic              is_store;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= ST_RESET;
      step  <= '0;
    end else begin
      state <= state_next;
      step  <= step_next;
    end
  end

  assign halt     = (state == ST_HALT);
  assign is_store = (dec.op_class == CLS_STORE);

  // lanes for the memory step, lane 3 is the lowest address
  always_comb begin
    case (dec.size)
      SIZE_WORD: lane_mask = bus.bus_align[1] ? {{(`LANES/2){1'b0}}, {(`LANES/2){1'b1}}}
                                              : {{(`LANES/2){1'b1}}, {(`LANES/2){1'b0}}};
      SIZE_BYTE: lane_mask = {1'b1, {(`LANES-1){1'b0}}} >> bus.bus_align;
      default:   lane_mask = '1;
    endcase
  end

  always_comb begin
    state_next = state;
    step_next  = step;
    eval_done  = 1'b0;

    ctrl                = '0;
    ctrl.alu_func       = `ALU_ADD;
    ctrl.alu1sel        = `ALU1SEL_RA;
    ctrl.alu2sel        = `ALU2SEL_RB;
    ctrl.regsel         = `REGSEL_ALU;
    ctrl.reg_read_addr1 = dec.fields.ra;
    ctrl.reg_read_addr2 = dec.fields.rb;
    ctrl.reg_write_addr = dec.fields.ra;
    ctrl.mdrsel         = `MDRSEL_NONE;
    ctrl.marsel         = `MARSEL_NONE;
    ctrl.pcsel          = `PCSEL_HOLD;
    ctrl.addrsel        = `ADDRSEL_PC;
    ctrl.byteenable     = '1;

    case (state)
      ST_RESET: begin
        case (step)
          0: begin
            ctrl.pcsel    = `PCSEL_VECTOR;  // address of reset vector
            ctrl.bus_read = 1'b1;
            if (bus.busfault) begin
              state_next = ST_EXCEPTION;
            end else if (!bus.bus_wait) begin
              step_next = step + 1'b1;
            end
          end
          1: begin
            ctrl.bus_read = 1'b1;
            ctrl.marsel   = `MARSEL_BUS;  // vector contents
            step_next     = step + 1'b1;
          end
          2: begin
            ctrl.pcsel = `PCSEL_MAR;
            state_next = ST_FETCH;
            step_next  = '0;
          end
          default: state_next = ST_HALT;
        endcase
      end

      ST_FETCH: begin
        case (step)
          0: begin
            ctrl.bus_read = 1'b1;
            if (bus.busfault) begin
              state_next = ST_EXCEPTION;
            end else if (!bus.bus_wait) begin
              step_next = step + 1'b1;
            end
          end
          1: begin
            ctrl.bus_read = 1'b1;
            ctrl.ir_write = 1'b1;
            step_next     = step + 1'b1;
          end
          2: begin
            ctrl.pcsel = `PCSEL_INC;
            state_next = ST_EVAL;
            step_next  = '0;
          end
          default: state_next = ST_HALT;
        endcase
      end

      ST_EVAL: begin
        ctrl.alu_func = dec.alu_func;
        case (dec.op_class)
          CLS_NOP: eval_done = 1'b1;
          CLS_CMP: begin
            ctrl.ccr_write = 1'b1;
            eval_done      = 1'b1;
          end
          CLS_UNARY, CLS_LDIU: begin
            ctrl.regsel    = dec.regsel;
            ctrl.reg_write = 1'b1;
            eval_done      = 1'b1;
          end
          CLS_BRANCH: begin
            if (taken) begin
              ctrl.pcsel = `PCSEL_REL;
            end
            eval_done = 1'b1;
          end
          CLS_ALU_RRR: begin
            ctrl.reg_read_addr1 = dec.fields.rb;
            ctrl.reg_read_addr2 = dec.fields.rc;
            if (step == '0) begin
              step_next = step + 1'b1;
            end else begin
              ctrl.reg_write = 1'b1;
              eval_done      = 1'b1;
            end
          end
          CLS_INC, CLS_DEC: begin
            if (step == '0) begin
              ctrl.alu2sel = `ALU2SEL_ONE;  // ra plus or minus one
              step_next    = step + 1'b1;
            end else begin
              ctrl.reg_write = 1'b1;
              eval_done      = 1'b1;
            end
          end
          CLS_LDA, CLS_JMP: begin
            if (step == '0) begin
              ctrl.reg_read_addr1 = dec.fields.rb;
              ctrl.alu2sel        = `ALU2SEL_IND;
              step_next           = step + 1'b1;
            end else begin
              if (dec.op_class == CLS_JMP) begin
                ctrl.pcsel = `PCSEL_ALU;
              end else begin
                ctrl.reg_write = 1'b1;
              end
              eval_done = 1'b1;
            end
          end
          CLS_LOAD, CLS_STORE: begin
            ctrl.addrsel = `ADDRSEL_MAR;
            case (step)
              0: begin
                ctrl.reg_read_addr1 = dec.fields.rb;
                ctrl.alu2sel        = `ALU2SEL_IND;  // effective address
                step_next           = step + 1'b1;
              end
              1: begin
                ctrl.marsel = `MARSEL_ALU;
                if (is_store) begin
                  ctrl.mdrsel = `MDRSEL_RA;
                end
                step_next = step + 1'b1;
              end
              2: begin
                ctrl.byteenable = lane_mask;
                if (is_store) begin
                  ctrl.bus_write = 1'b1;
                end else begin
                  ctrl.bus_read = 1'b1;
                  ctrl.mdrsel   = `MDRSEL_BUS;
                end
                if (bus.busfault) begin
                  state_next = ST_EXCEPTION;
                end else if (!bus.bus_wait) begin
                  step_next = step + 1'b1;
                end
              end
              default: begin
                if (!is_store) begin
                  ctrl.regsel    = `REGSEL_MDR;
                  ctrl.reg_write = 1'b1;
                end
                eval_done = 1'b1;
              end
            endcase
          end
          default: state_next = ST_HALT;  // undecoded
        endcase
        if (eval_done) begin
          state_next = ST_FETCH;
          step_next  = '0;
        end
      end

      ST_EXCEPTION: begin
        state_next = ST_HALT;
        step_next  = '0;
      end

      ST_HALT: state_next = ST_HALT;

      default: state_next = ST_HALT;
    endcase
  end

endmodule

// ==== hw/instr_decode.sv ====
`timescale 1ns/10ps
`include "control_defs.svh"

module instr_decode (
  input  logic [`DATA_W-1:0]    ir,
  output control_pkg::decoded_t dec
);
  import control_pkg::*;

  ir_fields_t f;
  logic       br_valid;
  cond_e      br_cond;

  assign f = ir[`DATA_W-1 -: $bits(ir_fields_t)];  // low bits are offset only

  // branch opcode to condition
  always_comb begin
    br_valid = 1'b1;
    case (f.opcode)
      `OP_BRA:  br_cond = COND_ALWAYS;
      `OP_BEQ:  br_cond = COND_EQ;
      `OP_BNE:  br_cond = COND_NE;
      `OP_BGTU: br_cond = COND_GTU;
      `OP_BGT:  br_cond = COND_GT;
      `OP_BGE:  br_cond = COND_GE;
      `OP_BLE:  br_cond = COND_LE;
      `OP_BLT:  br_cond = COND_LT;
      `OP_BGEU: br_cond = COND_GEU;
      `OP_BLTU: br_cond = COND_LTU;
      `OP_BLEU: br_cond = COND_LEU;
      `OP_BRN:  br_cond = COND_NEVER;
      default: begin
        br_valid = 1'b0;
        br_cond  = COND_NEVER;
      end
    endcase
  end

  always_comb begin
    dec.op_class = CLS_ILLEGAL;
    dec.size     = SIZE_LONG;
    dec.cond     = br_cond;
    dec.alu_func = `ALU_ADD;
    dec.regsel   = `REGSEL_ALU;
    dec.fields   = f;

    case (f.mode)
      `MODE_REG: begin
        casez (f.opcode)
          `OP_NOP: dec.op_class = CLS_NOP;
          `OP_INC: dec.op_class = CLS_INC;
          `OP_CMP: begin
            dec.op_class = CLS_CMP;
            dec.alu_func = `ALU_SUB;
          end
          `OP_DEC: begin
            dec.op_class = CLS_DEC;
            dec.alu_func = `ALU_SUB;
          end
          `OP_MOV, `OP_COM, `OP_NEG, `OP_EXTB, `OP_EXT: dec.op_class = CLS_UNARY;
          `OP_ALU_GRP: begin
            dec.op_class = CLS_ALU_RRR;
            dec.alu_func = f.opcode[2:0];
          end
          default: dec.op_class = CLS_ILLEGAL;
        endcase
        case (f.opcode)
          `OP_MOV:  dec.regsel = `REGSEL_RB;
          `OP_COM:  dec.regsel = `REGSEL_COM;
          `OP_NEG:  dec.regsel = `REGSEL_NEG;
          `OP_EXTB: dec.regsel = `REGSEL_EXTB;
          `OP_EXT:  dec.regsel = `REGSEL_EXTW;
          default:  dec.regsel = `REGSEL_ALU;
        endcase
      end
      `MODE_IMM: begin
        dec.regsel = `REGSEL_IMMU;  // only ldiu writes back
        if (br_valid) begin
          dec.op_class = CLS_BRANCH;
        end else if (f.opcode == `OP_LDIU) begin
          dec.op_class = CLS_LDIU;
        end
      end
      `MODE_REGIND: begin
        casez (f.opcode)
          `OP_LDA: dec.op_class = CLS_LDA;
          `OP_JMP: dec.op_class = CLS_JMP;
          `OP_ST_L, `OP_ST_W, `OP_ST_B: begin
            dec.op_class = CLS_STORE;
            dec.size     = access_size_e'(f.opcode[2:1]);
          end
          `OP_LD_L, `OP_LD_W, `OP_LD_B: begin
            dec.op_class = CLS_LOAD;
            dec.size     = access_size_e'(f.opcode[2:1]);
          end
          default: dec.op_class = CLS_ILLEGAL;
        endcase
      end
      default: dec.op_class = CLS_ILLEGAL;  // direct mode not supported
    endcase
  end

endmodule

// ==== include/control_defs.svh ====
`ifndef CONTROL_DEFS_SVH
`define CONTROL_DEFS_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define OPCODE_W    8
`define MODE_W      3
`define SEQ_W       3
`define CCR_W       4
`define LANES       4

`define MODE_REG     3'h0
`define MODE_REGIND  3'h1
`define MODE_IMM     3'h2

// register mode
`define OP_NOP      8'h50
`define OP_CMP      8'h02
`define OP_INC      8'h03
`define OP_DEC      8'h04
`define OP_MOV      8'h07
`define OP_COM      8'h08
`define OP_NEG      8'h09
`define OP_EXTB     8'h17
`define OP_EXT      8'h18
`define OP_ALU_GRP  8'h2?   // low three bits carry the alu function

// immediate mode
`define OP_BRA      8'h00
`define OP_BEQ      8'h01
`define OP_BNE      8'h02
`define OP_BGTU     8'h03
`define OP_BGT      8'h04
`define OP_BGE      8'h05
`define OP_BLE      8'h06
`define OP_BLT      8'h07
`define OP_BGEU     8'h08
`define OP_BLTU     8'h09
`define OP_BLEU     8'h0a
`define OP_BRN      8'h0b
`define OP_LDIU     8'h0d

// register indirect, upper nibble ignored
`define OP_ST_L     8'h?0
`define OP_LD_L     8'h?1
`define OP_ST_W     8'h?2
`define OP_LD_W     8'h?3
`define OP_ST_B     8'h?4
`define OP_LD_B     8'h?5
`define OP_LDA      8'h?a
`define OP_JMP      8'h?b

`define PCSEL_HOLD    3'h0
`define PCSEL_INC     3'h1
`define PCSEL_MAR     3'h2
`define PCSEL_REL     3'h3
`define PCSEL_ALU     3'h4
`define PCSEL_VECTOR  3'h5

`define REGSEL_ALU    4'h0
`define REGSEL_MDR    4'h1
`define REGSEL_NEG    4'h2
`define REGSEL_COM    4'h3
`define REGSEL_RB     4'h4
`define REGSEL_IMMU   4'h6
`define REGSEL_EXTB   4'h9
`define REGSEL_EXTW   4'ha

`define ALU1SEL_RA    3'h0
`define ALU2SEL_RB    3'h0
`define ALU2SEL_IND   3'h1   // rb plus indirect offset
`define ALU2SEL_ONE   3'h2

`define MDRSEL_NONE   3'h0
`define MDRSEL_BUS    3'h1
`define MDRSEL_RA     3'h3

`define MARSEL_NONE   2'h0
`define MARSEL_BUS    2'h1
`define MARSEL_ALU    2'h2

`define ADDRSEL_PC    1'b0
`define ADDRSEL_MAR   1'b1

`define ALU_ADD       3'h2
`define ALU_SUB       3'h3

`endif

// ==== run_sim.sh ====
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_control \
  --Mdir obj_dir -o tb_control > build.log 2>&1 \
  && ./obj_dir/tb_control > sim.log 2>&1 \
  || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Simulation PASSED" sim.log \
  && { echo "pass"; exit 0; } \
  || { echo "fail, see sim.log"; exit 1; }

// ==== testbench/tb_control_vectors.svh ====
`ifndef TB_CONTROL_VECTORS_SVH
`define TB_CONTROL_VECTORS_SVH

function automatic void add_vector(logic [`DATA_W-1:0] ir_w, ccr_t flags, logic [1:0] align,
                                   int waits, bit fault, int len, ctrl_word_t exp,
                                   bit exp_halt);
  vector_t v;
  v.ir       = ir_w;
  v.ccr      = flags;
  v.align    = align;
  v.waits    = waits;
  v.fault    = fault;
  v.len      = len;
  v.exp      = exp;
  v.exp_halt = exp_halt;
  table_q.push_back(v);
endfunction

function automatic void fill_table();
  ctrl_word_t         w;
  logic [`DATA_W-1:0] iw;
  logic [7:0]         opc;
  logic [7:0]         unary_op [5] = '{8'h07, 8'h08, 8'h09, 8'h17, 8'h18};
  logic [3:0]         unary_sel [5] = '{4'h4, 4'h3, 4'h2, 4'h9, 4'ha};
  logic [3:0]         ccr_set [6] = '{4'h0, 4'h1, 4'h8, 4'h4, 4'h6, 4'h2};

  iw = make_ir(`MODE_REG, `OP_NOP, 5'd1, 5'd2, 5'd3);
  w = base_word(iw);
  add_vector(iw, '0, 2'd0, 1, 1'b0, 1, w, 1'b0);

  iw = make_ir(`MODE_REG, `OP_CMP, 5'd7, 5'd8, 5'd9);
  w = base_word(iw);
  w.alu_func  = `ALU_SUB;
  w.ccr_write = 1'b1;
  add_vector(iw, '0, 2'd0, 0, 1'b0, 1, w, 1'b0);

  iw = make_ir(`MODE_REG, 8'h25, 5'd4, 5'd5, 5'd6);  // alu group, func 5
  w = base_word(iw);
  w.alu_func       = 3'h5;
  w.reg_read_addr1 = 5'd5;
  w.reg_read_addr2 = 5'd6;
  w.reg_write      = 1'b1;
  add_vector(iw, '0, 2'd0, 2, 1'b0, 2, w, 1'b0);

  iw = make_ir(`MODE_REG, `OP_INC, 5'd10, 5'd11, 5'd12);
  w = base_word(iw);
  w.reg_write = 1'b1;
  add_vector(iw, '0, 2'd0, 0, 1'b0, 2, w, 1'b0);

  iw = make_ir(`MODE_REG, `OP_DEC, 5'd13, 5'd14, 5'd15);
  w = base_word(iw);
  w.alu_func  = `ALU_SUB;
  w.reg_write = 1'b1;
  add_vector(iw, '0, 2'd0, 1, 1'b0, 2, w, 1'b0);

  for (int i = 0; i < 5; i++) begin  // mov com neg ext.b ext
    iw = make_ir(`MODE_REG, unary_op[i], 5'd16, 5'd17, 5'd18);
    w = base_word(iw);
    w.regsel    = unary_sel[i];
    w.reg_write = 1'b1;
    add_vector(iw, '0, 2'd0, i % 2, 1'b0, 1, w, 1'b0);
  end

  iw = make_ir(`MODE_IMM, `OP_LDIU, 5'd19, 5'd20, 5'd21);
  w = base_word(iw);
  w.regsel    = `REGSEL_IMMU;
  w.reg_write = 1'b1;
  add_vector(iw, '0, 2'd0, 0, 1'b0, 1, w, 1'b0);

  iw = make_ir(`MODE_REGIND, 8'h3a, 5'd22, 5'd23, 5'd24);  // lda
  w = base_word(iw);
  w.reg_write = 1'b1;
  add_vector(iw, '0, 2'd0, 1, 1'b0, 2, w, 1'b0);

  iw = make_ir(`MODE_REGIND, 8'hcb, 5'd25, 5'd26, 5'd27);  // jmp
  w = base_word(iw);
  w.pcsel = `PCSEL_ALU;
  add_vector(iw, '0, 2'd0, 0, 1'b0, 2, w, 1'b0);

  for (int s = 0; s < 12; s++) begin  // every branch against every flag set
    for (int k = 0; k < 6; k++) begin
      opc = 8'(s);
      iw = make_ir(`MODE_IMM, opc, 5'd3, 5'd4, 5'd5);
      w = base_word(iw);
      if (cond_holds(s, ccr_set[k])) begin
        w.pcsel = `PCSEL_REL;
      end
      add_vector(iw, ccr_set[k], 2'd0, k % 2, 1'b0, 1, w, 1'b0);
    end
  end

  for (int s = 0; s < 3; s++) begin  // long word byte
    for (int a = 0; a < 4; a++) begin
      for (int ld = 0; ld < 2; ld++) begin
        opc = {4'h9, 1'b0, 2'(s), 1'(ld)};
        iw = make_ir(`MODE_REGIND, opc, 5'd6, 5'd7, 5'd8);
        w = base_word(iw);
        w.addrsel    = `ADDRSEL_MAR;
        w.byteenable = lanes(s, 2'(a));
        if (ld == 1) begin
          w.bus_read = 1'b1;
          w.mdrsel   = `MDRSEL_BUS;
        end else begin
          w.bus_write = 1'b1;
        end
        add_vector(iw, '0, 2'(a), (s + a + ld) % 3, 1'b0, 4, w, 1'b0);
      end
    end
  end

  iw = make_ir(`MODE_REG, 8'h60, 5'd1, 5'd1, 5'd1);  // undecoded
  w = base_word(iw);
  add_vector(iw, '0, 2'd0, 0, 1'b0, 1, w, 1'b1);

  iw = make_ir(`MODE_REGIND, 8'h01, 5'd2, 5'd3, 5'd4);  // long load, faults
  w = base_word(iw);
  w.addrsel  = `ADDRSEL_MAR;
  w.bus_read = 1'b1;
  w.mdrsel   = `MDRSEL_BUS;
  add_vector(iw, '0, 2'd0, 0, 1'b1, 4, w, 1'b1);
endfunction

`endif

// ==== testbench/tb_control.sv ====
`timescale 1ns/10ps
`include "control_defs.svh"

module tb_control;
  import control_pkg::*;

  typedef struct {
    logic [`DATA_W-1:0] ir;
    ccr_t               ccr;
    logic [1:0]         align;
    int                 waits;
    bit                 fault;
    int                 len;   // eval cycles without waits
    ctrl_word_t         exp;   // decisive eval step
    bit                 exp_halt;
  } vector_t;

  logic               clock;
  logic               reset_n;
  logic [`DATA_W-1:0] ir;
  ccr_t               ccr;
  bus_status_t        bus;
  ctrl_word_t         ctrl;
  logic               halt;

  vector_t table_q[$];
  int      errors = 0;
  int      cycles = 0;
  int      limit = 0;
  integer  seed = 32'h0d419b9f;

  control_top uut (
    .clock   (clock),
    .reset_n (reset_n),
    .ir      (ir),
    .ccr     (ccr),
    .bus     (bus),
    .ctrl    (ctrl),
    .halt    (halt)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout after %0d cycles, the test sequence did not complete", cycles);
      $display("errors: %0d", errors);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [`DATA_W-1:0] make_ir(logic [2:0] mode, logic [7:0] opc,
                                                 logic [4:0] ra, logic [4:0] rb,
                                                 logic [4:0] rc);
    return {mode, opc, ra, rb, rc, 6'h1a};  // low bits are the offset
  endfunction

  // idle word of the datapath
  function automatic ctrl_word_t base_word(logic [`DATA_W-1:0] w);
    ir_fields_t f;
    ctrl_word_t c;
    f = w[`DATA_W-1 -: $bits(ir_fields_t)];
    c = '0;
    c.alu_func       = `ALU_ADD;
    c.alu1sel        = `ALU1SEL_RA;
    c.alu2sel        = `ALU2SEL_RB;
    c.regsel         = `REGSEL_ALU;
    c.reg_read_addr1 = f.ra;
    c.reg_read_addr2 = f.rb;
    c.reg_write_addr = f.ra;
    c.pcsel          = `PCSEL_HOLD;
    c.addrsel        = `ADDRSEL_PC;
    c.byteenable     = '1;
    return c;
  endfunction

  function automatic logic [3:0] lanes(int size, logic [1:0] align);
    case (size)
      1:       return align[1] ? 4'b0011 : 4'b1100;
      2: begin
        case (align)  // align 0 is the top lane
          2'd0:    return 4'b1000;
          2'd1:    return 4'b0100;
          2'd2:    return 4'b0010;
          default: return 4'b0001;
        endcase
      end
      default: return 4'b1111;
    endcase
  endfunction

  // branch rules, indexed by immediate opcode
  function automatic logic cond_holds(int opc, ccr_t f);
    case (opc)
      0:       return 1'b1;
      1:       return f.zero;
      2:       return !f.zero;
      3:       return !f.carry && !f.zero;
      4:       return !f.zero && (f.negative == f.overflow);
      5:       return f.negative == f.overflow;
      6:       return f.zero || (f.negative != f.overflow);
      7:       return f.negative != f.overflow;
      8:       return !f.carry;
      9:       return f.carry;
      10:      return f.carry || f.zero;
      default: return 1'b0;
    endcase
  endfunction

  `include "tb_control_vectors.svh"

  task automatic report_field(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error ctrl.%s: got %h expected %h at cycle %0d", name, got, exp, cycles);
    end
  endtask

  task automatic check_ctrl(ctrl_word_t got, ctrl_word_t exp);
    report_field("ir_write", 32'(got.ir_write), 32'(exp.ir_write));
    report_field("ccr_write", 32'(got.ccr_write), 32'(exp.ccr_write));
    report_field("alu_func", 32'(got.alu_func), 32'(exp.alu_func));
    report_field("alu1sel", 32'(got.alu1sel), 32'(exp.alu1sel));
    report_field("alu2sel", 32'(got.alu2sel), 32'(exp.alu2sel));
    report_field("regsel", 32'(got.regsel), 32'(exp.regsel));
    report_field("reg_read_addr1", 32'(got.reg_read_addr1), 32'(exp.reg_read_addr1));
    report_field("reg_read_addr2", 32'(got.reg_read_addr2), 32'(exp.reg_read_addr2));
    report_field("reg_write_addr", 32'(got.reg_write_addr), 32'(exp.reg_write_addr));
    report_field("reg_write", 32'(got.reg_write), 32'(exp.reg_write));
    report_field("mdrsel", 32'(got.mdrsel), 32'(exp.mdrsel));
    report_field("marsel", 32'(got.marsel), 32'(exp.marsel));
    report_field("pcsel", 32'(got.pcsel), 32'(exp.pcsel));
    report_field("addrsel", 32'(got.addrsel), 32'(exp.addrsel));
    report_field("byteenable", 32'(got.byteenable), 32'(exp.byteenable));
    report_field("bus_read", 32'(got.bus_read), 32'(exp.bus_read));
    report_field("bus_write", 32'(got.bus_write), 32'(exp.bus_write));
  endtask

  task automatic check_halt(logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("error halt: got %h expected %h at cycle %0d", got, exp, cycles);
    end
  endtask

  // sample mid cycle, return on the next rising edge
  task automatic check_cycle(ctrl_word_t exp, bit with_ctrl, logic exp_halt);
    @(negedge clock);
    if (with_ctrl) begin
      check_ctrl(ctrl, exp);
    end
    check_halt(halt, exp_halt);
    @(posedge clock);
  endtask

  task automatic apply_reset();
    ctrl_word_t w;
    reset_n <= 1'b0;
    ir      <= '0;
    ccr     <= '0;
    bus     <= '0;
    repeat (8) @(posedge clock);
    reset_n <= 1'b1;
    w = base_word('0);
    w.pcsel    = `PCSEL_VECTOR;
    w.bus_read = 1'b1;
    check_cycle(w, 1'b1, 1'b0);
    w = base_word('0);
    w.bus_read = 1'b1;
    w.marsel   = `MARSEL_BUS;
    check_cycle(w, 1'b1, 1'b0);
    w = base_word('0);
    w.pcsel = `PCSEL_MAR;
    check_cycle(w, 1'b1, 1'b0);
  endtask

  task automatic run_vector(vector_t v);
    ctrl_word_t w;
    int         fetch_waits;
    int         bus_waits;
    if (v.len == 4) begin
      fetch_waits = $unsigned($random(seed)) % (v.waits + 1);  // split between bus steps
    end else begin
      fetch_waits = v.waits;
    end
    bus_waits = v.waits - fetch_waits;
    ir            <= v.ir;
    ccr           <= v.ccr;
    bus.bus_align <= v.align;
    bus.busfault  <= 1'b0;

    w = base_word(v.ir);
    w.bus_read = 1'b1;
    for (int i = 0; i <= fetch_waits; i++) begin
      bus.bus_wait <= (i < fetch_waits);
      check_cycle(w, 1'b1, 1'b0);
    end
    bus.bus_wait <= 1'b0;
    w.ir_write = 1'b1;
    check_cycle(w, 1'b1, 1'b0);
    w = base_word(v.ir);
    w.pcsel = `PCSEL_INC;
    check_cycle(w, 1'b1, 1'b0);

    if (v.len == 4) begin
      check_cycle(w, 1'b0, 1'b0);  // address
      check_cycle(w, 1'b0, 1'b0);  // mar
      for (int i = 0; i <= bus_waits; i++) begin
        bus.bus_wait <= (i < bus_waits);
        bus.busfault <= v.fault;
        check_cycle(v.exp, 1'b1, 1'b0);
      end
      bus.bus_wait <= 1'b0;
      bus.busfault <= 1'b0;
      if (v.fault) begin
        check_cycle(w, 1'b0, 1'b0);  // exception
        check_cycle(w, 1'b0, 1'b1);
        check_cycle(w, 1'b0, 1'b1);
      end else begin
        w = base_word(v.ir);
        w.addrsel = `ADDRSEL_MAR;
        if (v.exp.bus_read) begin
          w.regsel    = `REGSEL_MDR;
          w.reg_write = 1'b1;
        end
        check_cycle(w, 1'b1, 1'b0);
      end
    end else if (v.exp_halt) begin
      check_cycle(v.exp, 1'b1, 1'b0);
      check_cycle(w, 1'b0, 1'b1);
      check_cycle(w, 1'b0, 1'b1);
    end else begin
      for (int i = 1; i < v.len; i++) begin
        check_cycle(w, 1'b0, 1'b0);
      end
      check_cycle(v.exp, 1'b1, 1'b0);
    end
  endtask

  initial begin
    fill_table();
    limit = table_q.size() * 16 + 50;
    apply_reset();
    foreach (table_q[i]) begin
      if (i > 0 && table_q[i-1].exp_halt) begin
        apply_reset();  // leave halt
      end
      run_vector(table_q[i]);
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
